/* verilog/alu_pkg.sv */
// shared widths, register offsets, opcode and width codes, flag bits, control word, width helpers
package alu_pkg;

    localparam int data_w = 32;

    // register byte offsets
    localparam int unsigned op0_addr    = 'h00;
    localparam int unsigned op1_addr    = 'h04;
    localparam int unsigned ctrl_addr   = 'h08; // write only, starts an operation
    localparam int unsigned result_addr = 'h0C;
    localparam int unsigned flags_addr  = 'h10;
    localparam int unsigned status_addr = 'h14; // bit 0 busy

    // shift codes all have bit 4 set
    typedef enum logic [4:0] {
        op_move = 5'h00,
        op_add  = 5'h01,
        op_adc  = 5'h02,
        op_sub  = 5'h03,
        op_sbc  = 5'h04,
        op_neg  = 5'h05,
        op_and  = 5'h06,
        op_or   = 5'h07,
        op_xor  = 5'h08,
        op_cpl  = 5'h09,
        op_scf  = 5'h0A,
        op_rcf  = 5'h0B,
        op_ccf  = 5'h0C,
        op_rlc  = 5'h10,
        op_rrc  = 5'h11,
        op_rl   = 5'h12,
        op_rr   = 5'h13,
        op_sla  = 5'h14,
        op_sra  = 5'h15,
        op_sll  = 5'h16,
        op_srl  = 5'h17
    } alu_op_e;

    typedef enum logic [1:0] {
        w_byte = 2'd0,
        w_word = 2'd1,
        w_long = 2'd2  // code 3 also runs as long
    } width_e;

    // flag byte is S Z 0 H 0 V N C
    localparam int flag_s = 7;
    localparam int flag_z = 6;
    localparam int flag_h = 4;
    localparam int flag_v = 2;
    localparam int flag_n = 1;
    localparam int flag_c = 0;

    typedef union packed {
        struct packed {
            logic [22:0] rsvd_hi;
            logic        flags_only; // flags update, result kept
            logic        rsvd_lo;
            width_e      width;
            alu_op_e     op;
        } arith;
        struct packed {
            logic [19:0] rsvd_hi;
            logic [3:0]  count;      // 0 means 16 steps
            logic        rsvd_lo;
            width_e      width;
            alu_op_e     op;
        } shift;
    } ctrl_word_u;

    function automatic logic is_shift_op(alu_op_e op);
        return op[4];
    endfunction

    function automatic logic sign_at(logic [data_w-1:0] x, width_e w);
        case (w)
            w_byte:  return x[7];
            w_word:  return x[15];
            default: return x[31];
        endcase
    endfunction

    function automatic logic zero_at(logic [data_w-1:0] x, width_e w);
        case (w)
            w_byte:  return x[7:0] == '0;
            w_word:  return x[15:0] == '0;
            default: return x == '0;
        endcase
    endfunction

    function automatic logic even_at(logic [data_w-1:0] x, width_e w);
        case (w)
            w_byte:  return ~^x[7:0];
            w_word:  return ~^x[15:0];
            default: return ~^x;
        endcase
    endfunction

endpackage

/* verilog/apb_regs.sv */
// apb_regs: APB write decode, operand and control registers, start pulse, slave error
`timescale 1ns/100ps

module apb_regs import alu_pkg::*; #(
    parameter int ADDR_W = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [ADDR_W-1:0] paddr,
    input  logic [data_w-1:0] pwdata,
    input  logic              busy,
    output logic              pready,
    output logic              pslverr,
    output logic [data_w-1:0] op0,
    output logic [data_w-1:0] op1,
    output ctrl_word_u        ctrl,
    output logic              start
);

    logic access;
    logic hit_op0;
    logic hit_op1;
    logic hit_ctrl;
    logic hit_ro;
    logic wr_err;
    logic rd_err;
    logic wr_ok;

    assign access   = psel && penable; // access phase
    assign hit_op0  = paddr == ADDR_W'(op0_addr);
    assign hit_op1  = paddr == ADDR_W'(op1_addr);
    assign hit_ctrl = paddr == ADDR_W'(ctrl_addr);
    assign hit_ro   = (paddr == ADDR_W'(result_addr)) ||
                      (paddr == ADDR_W'(flags_addr))  ||
                      (paddr == ADDR_W'(status_addr));

    // read-only and unmapped writes fail, and so does a new ctrl while busy
    assign wr_err = !(hit_op0 || hit_op1 || hit_ctrl) || (hit_ctrl && busy);
    assign rd_err = !(hit_op0 || hit_op1 || hit_ro);   // ctrl is write only

    assign pready  = 1'b1; // no wait states
    assign pslverr = access && (pwrite ? wr_err : rd_err);
    assign wr_ok   = access && pwrite && !wr_err;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            op0   <= '0;
            op1   <= '0;
            ctrl  <= '0;
            start <= 1'b0;
        end else begin
            start <= wr_ok && hit_ctrl; // one cycle after the ctrl access
            if (wr_ok && hit_op0) begin
                op0 <= pwdata;
            end
            if (wr_ok && hit_op1) begin
                op1 <= pwdata;
            end
            if (wr_ok && hit_ctrl) begin
                ctrl <= pwdata;
            end
        end
    end

    // setup phase must come first
    assert property (@(posedge clk) disable iff (rst) $rose(penable) |-> psel)
        else $error("penable rose without psel");

    // result_regs busy must have been low during the ctrl access
    assert property (@(posedge clk) disable iff (rst) start |-> $past(!busy))
        else $error("start issued while busy");

endmodule

/* verilog/alu_core.sv */
// alu_core: single-cycle arithmetic, logic and carry-flag operations with flag generation
`timescale 1ns/100ps

module alu_core import alu_pkg::*; (
    input  logic [data_w-1:0] op0,
    input  logic [data_w-1:0] op1,
    input  ctrl_word_u        ctrl,
    input  logic [7:0]        flags_in,
    output logic [data_w-1:0] core_result,
    output logic [7:0]        core_flags,
    output logic              core_write_result
);

    alu_op_e           op;
    width_e            w;
    logic              is_sub;
    logic              cin;
    logic [data_w-1:0] a;
    logic [data_w-1:0] b;
    logic [data_w-1:0] sum;
    logic [data_w-1:0] raw;
    logic [data_w-1:0] mask;
    logic              hc;
    logic              c0;
    logic              c1;
    logic              c2;
    logic              cw;
    logic              a_s;
    logic              b_s;
    logic              r_s;
    logic              ovf;

    assign op     = ctrl.arith.op;
    assign w      = ctrl.arith.width;
    assign is_sub = op inside {op_sub, op_sbc, op_neg};
    assign cin    = (op == op_adc || op == op_sbc) && flags_in[flag_c];

    // NEG goes through the subtractor as 0 - op0
    assign a = (op == op_neg) ? '0 : op0;
    assign b = (op == op_neg) ? op0 : op1;

    // sliced so half carry and byte/word carries fall out directly
    always_comb begin
        if (is_sub) begin
            {hc, sum[3:0]}   = {1'b0, a[3:0]}   - {1'b0, b[3:0]}   - {4'd0, cin};
            {c0, sum[7:4]}   = {1'b0, a[7:4]}   - {1'b0, b[7:4]}   - {4'd0, hc};
            {c1, sum[15:8]}  = {1'b0, a[15:8]}  - {1'b0, b[15:8]}  - {8'd0, c0};
            {c2, sum[31:16]} = {1'b0, a[31:16]} - {1'b0, b[31:16]} - {16'd0, c1};
        end else begin
            {hc, sum[3:0]}   = {1'b0, a[3:0]}   + {1'b0, b[3:0]}   + {4'd0, cin};
            {c0, sum[7:4]}   = {1'b0, a[7:4]}   + {1'b0, b[7:4]}   + {4'd0, hc};
            {c1, sum[15:8]}  = {1'b0, a[15:8]}  + {1'b0, b[15:8]}  + {8'd0, c0};
            {c2, sum[31:16]} = {1'b0, a[31:16]} + {1'b0, b[31:16]} + {16'd0, c1};
        end
    end

    assign cw  = (w == w_byte) ? c0 : (w == w_word) ? c1 : c2;
    assign a_s = sign_at(a, w);
    assign b_s = sign_at(b, w);
    assign r_s = sign_at(sum, w);
    assign ovf = (is_sub ? (a_s != b_s) : (a_s == b_s)) && (r_s != a_s);

    always_comb begin
        case (w)
            w_byte:  mask = 32'h0000_00FF;
            w_word:  mask = 32'h0000_FFFF;
            default: mask = 32'hFFFF_FFFF;
        endcase
    end

    always_comb begin
        raw        = op0;
        core_flags = flags_in;
        case (op)
            op_move: raw = op1; // flags untouched
            op_add, op_adc, op_sub, op_sbc, op_neg: begin
                raw                = sum;
                core_flags[flag_s] = r_s;
                core_flags[flag_z] = zero_at(sum, w);
                core_flags[flag_h] = hc;
                core_flags[flag_v] = ovf;
                core_flags[flag_n] = is_sub;
                core_flags[flag_c] = cw;
            end
            op_and, op_or, op_xor: begin
                if (op == op_and) begin
                    raw = op0 & op1;
                end else if (op == op_or) begin
                    raw = op0 | op1;
                end else begin
                    raw = op0 ^ op1;
                end
                core_flags[flag_s] = sign_at(raw, w);
                core_flags[flag_z] = zero_at(raw, w);
                core_flags[flag_h] = op == op_and;
                core_flags[flag_v] = even_at(raw, w); // parity
                core_flags[flag_n] = 1'b0;
                core_flags[flag_c] = 1'b0;
            end
            op_cpl: begin
                raw                = ~op1;
                core_flags[flag_h] = 1'b1;
                core_flags[flag_n] = 1'b1;
            end
            op_scf, op_rcf: begin
                core_flags[flag_c] = op == op_scf;
                core_flags[flag_n] = 1'b0;
                core_flags[flag_h] = 1'b0;
            end
            op_ccf: begin
                core_flags[flag_c] = ~flags_in[flag_c];
                core_flags[flag_n] = 1'b0; // H kept
            end
            default: ;
        endcase
    end

    // bits above the width keep op0
    assign core_result = (raw & mask) | (op0 & ~mask);

    assign core_write_result = !ctrl.arith.flags_only && !(op inside {op_scf, op_rcf, op_ccf});

endmodule

/* verilog/shift_unit.sv */
// shift_unit: one-bit-per-cycle shift and rotate engine with step counter
`timescale 1ns/100ps

module shift_unit import alu_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  logic [data_w-1:0] op0,
    input  ctrl_word_u        ctrl,
    input  logic [7:0]        flags_in,
    output logic [data_w-1:0] shift_result,
    output logic [7:0]        shift_flags,
    output logic              shift_done
);

    width_e            w;
    logic              load;
    logic [4:0]        steps;
    logic [4:0]        cnt;     // steps still to go after this one
    logic [data_w-1:0] data_q;
    logic              carry_q;
    logic [data_w-1:0] src;
    logic              cin;
    logic              left;
    logic              lin;
    logic              rin;
    logic              cout;

    assign w     = ctrl.shift.width;
    assign load  = start && is_shift_op(ctrl.shift.op);
    assign steps = (ctrl.shift.count == 4'd0) ? 5'd16 : {1'b0, ctrl.shift.count};

    // first step works straight on op0 in the start cycle
    assign src = load ? op0 : data_q;
    assign cin = load ? flags_in[flag_c] : carry_q;

    always_comb begin
        left = ctrl.shift.op inside {op_rlc, op_rl, op_sla, op_sll};
        lin  = 1'b0;
        rin  = 1'b0;
        case (ctrl.shift.op)
            op_rlc:  lin = sign_at(src, w);
            op_rl:   lin = cin;
            op_rrc:  rin = src[0];
            op_rr:   rin = cin;
            op_sra:  rin = sign_at(src, w); // sign fill
            default: ;
        endcase
        cout = left ? sign_at(src, w) : src[0];

        shift_result = src;
        case (w)
            w_byte:  shift_result[7:0]  = left ? {src[6:0], lin}  : {rin, src[7:1]};
            w_word:  shift_result[15:0] = left ? {src[14:0], lin} : {rin, src[15:1]};
            default: shift_result       = left ? {src[30:0], lin} : {rin, src[31:1]};
        endcase

        shift_flags         = 8'h00; // H and N stay 0
        shift_flags[flag_s] = sign_at(shift_result, w);
        shift_flags[flag_z] = zero_at(shift_result, w);
        shift_flags[flag_v] = even_at(shift_result, w);
        shift_flags[flag_c] = cout;
    end

    assign shift_done = load ? (steps == 5'd1) : (cnt == 5'd1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (load) begin
            cnt <= steps - 5'd1;
        end else if (cnt != '0) begin
            cnt <= cnt - 5'd1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            data_q  <= '0;
            carry_q <= 1'b0;
        end else if (load || cnt != '0) begin
            data_q  <= shift_result;
            carry_q <= cout;
        end
    end

    assert property (@(posedge clk) disable iff (rst) cnt <= 5'd16)
        else $error("shift step counter above 16");

endmodule

/* verilog/result_regs.sv */
// result_regs: busy state, result and flag registers, status, APB read mux
`timescale 1ns/100ps

module result_regs import alu_pkg::*; #(
    parameter int ADDR_W = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  logic [data_w-1:0] op0,
    input  logic [data_w-1:0] op1,
    input  ctrl_word_u        ctrl,
    input  logic [data_w-1:0] core_result,
    input  logic [7:0]        core_flags,
    input  logic              core_write_result,
    input  logic [data_w-1:0] shift_result,
    input  logic [7:0]        shift_flags,
    input  logic              shift_done,
    input  logic              psel,
    input  logic              pwrite,
    input  logic [ADDR_W-1:0] paddr,
    output logic              busy,
    output logic [7:0]        flags,
    output logic [data_w-1:0] prdata
);

    logic              is_shift;
    logic              pending;  // shift running
    logic [data_w-1:0] result_q;
    logic [data_w-1:0] op0_q;
    logic [data_w-1:0] op1_q;

    assign is_shift = is_shift_op(ctrl.arith.op);

    // start cycle counts as busy, so a single-cycle op is busy for one cycle
    assign busy = start || pending;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending  <= 1'b0;
            result_q <= '0;
            flags    <= '0;
            op0_q    <= '0;
            op1_q    <= '0;
        end else begin
            if (shift_done) begin
                pending  <= 1'b0;
                result_q <= shift_result;
                flags    <= shift_flags;
            end else if (start) begin
                pending <= is_shift;
                if (!is_shift) begin
                    if (core_write_result) begin
                        result_q <= core_result;
                    end
                    flags <= core_flags;
                end
            end
            if (start) begin
                op0_q <= op0;
                op1_q <= op1;
            end
        end
    end

    always_comb begin
        prdata = '0;
        if (psel && !pwrite) begin
            case (paddr)
                ADDR_W'(op0_addr):    prdata = op0_q;
                ADDR_W'(op1_addr):    prdata = op1_q;
                ADDR_W'(result_addr): prdata = result_q;
                ADDR_W'(flags_addr):  prdata = {{(data_w-8){1'b0}}, flags};
                ADDR_W'(status_addr): prdata = {{(data_w-1){1'b0}}, busy};
                default:              prdata = '0;
            endcase
        end
    end

    // a shift only finishes inside a started operation
    assert property (@(posedge clk) disable iff (rst) shift_done |-> busy)
        else $error("shift_done while not busy");

endmodule

/* verilog/alu_periph.sv */
// alu_periph: APB arithmetic peripheral top level
`timescale 1ns/100ps

module alu_periph import alu_pkg::*; #(
    parameter int ADDR_W = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [ADDR_W-1:0] paddr,
    input  logic [data_w-1:0] pwdata,
    output logic [data_w-1:0] prdata,
    output logic              pready,
    output logic              pslverr
);

    logic [data_w-1:0] op0;
    logic [data_w-1:0] op1;
    ctrl_word_u        ctrl;
    logic              start;
    logic              busy;
    logic [7:0]        flags;
    logic [data_w-1:0] core_result;
    logic [7:0]        core_flags;
    logic              core_write_result;
    logic [data_w-1:0] shift_result;
    logic [7:0]        shift_flags;
    logic              shift_done;

    apb_regs #(.ADDR_W(ADDR_W)) u_apb_regs (
        .clk(clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .busy(busy), .pready(pready),
        .pslverr(pslverr), .op0(op0), .op1(op1), .ctrl(ctrl), .start(start)
    );

    alu_core u_alu_core (
        .op0(op0), .op1(op1), .ctrl(ctrl), .flags_in(flags),
        .core_result(core_result), .core_flags(core_flags),
        .core_write_result(core_write_result)
    );

    shift_unit u_shift_unit (
        .clk(clk), .rst(rst), .start(start), .op0(op0), .ctrl(ctrl), .flags_in(flags),
        .shift_result(shift_result), .shift_flags(shift_flags), .shift_done(shift_done)
    );

    result_regs #(.ADDR_W(ADDR_W)) u_result_regs (
        .clk(clk), .rst(rst), .start(start), .op0(op0), .op1(op1), .ctrl(ctrl),
        .core_result(core_result), .core_flags(core_flags),
        .core_write_result(core_write_result), .shift_result(shift_result),
        .shift_flags(shift_flags), .shift_done(shift_done), .psel(psel),
        .pwrite(pwrite), .paddr(paddr), .busy(busy), .flags(flags), .prdata(prdata)
    );

endmodule

/* sim/tb_alu_periph.sv */
// testbench for alu_periph: APB driver, reference model, checks and timeout
`timescale 1ns/100ps

module tb_alu_periph;

    localparam int max_cycles = 20000; // ~920 ops, mostly 12 cycles, shifts up to ~30

    // register map
    localparam logic [7:0] a_op0    = 8'h00;
    localparam logic [7:0] a_op1    = 8'h04;
    localparam logic [7:0] a_ctrl   = 8'h08;
    localparam logic [7:0] a_result = 8'h0C;
    localparam logic [7:0] a_flags  = 8'h10;
    localparam logic [7:0] a_status = 8'h14;

    localparam logic [4:0] op_move = 5'h00;
    localparam logic [4:0] op_add  = 5'h01;
    localparam logic [4:0] op_adc  = 5'h02;
    localparam logic [4:0] op_sub  = 5'h03;
    localparam logic [4:0] op_sbc  = 5'h04;
    localparam logic [4:0] op_neg  = 5'h05;
    localparam logic [4:0] op_and  = 5'h06;
    localparam logic [4:0] op_or   = 5'h07;
    localparam logic [4:0] op_xor  = 5'h08;
    localparam logic [4:0] op_cpl  = 5'h09;
    localparam logic [4:0] op_scf  = 5'h0A;
    localparam logic [4:0] op_rcf  = 5'h0B;
    localparam logic [4:0] op_ccf  = 5'h0C;
    localparam logic [4:0] op_rlc  = 5'h10;
    localparam logic [4:0] op_rrc  = 5'h11;
    localparam logic [4:0] op_rl   = 5'h12;
    localparam logic [4:0] op_rr   = 5'h13;
    localparam logic [4:0] op_sla  = 5'h14;
    localparam logic [4:0] op_sra  = 5'h15;
    localparam logic [4:0] op_sll  = 5'h16;
    localparam logic [4:0] op_srl  = 5'h17;

    logic        clk;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    int          errors;
    int          cycles;
    integer      seed;
    logic [31:0] exp_result; // model state, mirrors the DUT registers
    logic [7:0]  exp_flags;
    logic [31:0] x;
    logic [31:0] y;
    logic [31:0] rd;
    logic [4:0]  arith_ops [6] = '{op_add, op_adc, op_sub, op_sbc, op_neg, op_move};
    logic [4:0]  logic_ops [4] = '{op_and, op_or, op_xor, op_cpl};
    logic [4:0]  flag_seq  [6] = '{op_and, op_ccf, op_scf, op_ccf, op_rcf, op_ccf};
    logic [4:0]  shift_ops [8] = '{op_rlc, op_rrc, op_rl, op_rr, op_sla, op_sra, op_sll, op_srl};

    alu_periph #(.ADDR_W(8)) UUT (
        .clk(clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp)
        else begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    // called and returns 1 ns after a rising edge, so transfers run back to back
    task automatic apb_transfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                                output logic [31:0] rdata, output logic err, output logic rdy);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1 penable = 1'b1;
        @(negedge clk); // mid access phase
        rdata = prdata;
        err   = pslverr;
        rdy   = pready;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                             input logic exp_err, input string name);
        logic [31:0] unused;
        logic        err;
        logic        rdy;
        apb_transfer(1'b1, addr, data, unused, err, rdy);
        check_value({name, " pslverr"}, {31'b0, exp_err}, {31'b0, err});
        check_value({name, " pready"}, 32'h1, {31'b0, rdy});
    endtask

    task automatic read_reg(input logic [7:0] addr, input logic exp_err, input string name,
                            output logic [31:0] data);
        logic err;
        logic rdy;
        apb_transfer(1'b0, addr, 32'h0, data, err, rdy);
        check_value({name, " pslverr"}, {31'b0, exp_err}, {31'b0, err});
        check_value({name, " pready"}, 32'h1, {31'b0, rdy});
    endtask

    task automatic wait_idle();
        logic [31:0] st;
        st = 32'h1;
        while (st[0]) begin
            read_reg(a_status, 1'b0, "status poll", st);
        end
    endtask

    // expected result and flags from the flag rules, S Z 0 H 0 V N C
    task automatic model_op(input logic [4:0] op, input logic [1:0] w, input logic fo,
                            input logic [3:0] cnt, input logic [31:0] a0, input logic [31:0] a1);
        logic [31:0] msk;
        int          top;
        logic [63:0] full;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic        h;
        logic        v;
        logic        c;
        logic        lin;
        logic        sub;
        int          n;
        msk = (w == 2'd0) ? 32'hFF : (w == 2'd1) ? 32'hFFFF : 32'hFFFF_FFFF;
        top = (w == 2'd0) ? 7 : (w == 2'd1) ? 15 : 31;
        if (op[4]) begin
            n = (cnt == 4'd0) ? 16 : int'(cnt);
            r = a0;
            c = exp_flags[0];
            repeat (n) begin
                if (op inside {op_rlc, op_rl, op_sla, op_sll}) begin
                    lin = (op == op_rlc) ? r[top] : (op == op_rl) ? c : 1'b0;
                    c   = r[top];
                    r   = (((r << 1) | {31'b0, lin}) & msk) | (r & ~msk);
                end else begin
                    lin = (op == op_rrc) ? r[0] : (op == op_rr) ? c :
                          (op == op_sra) ? r[top] : 1'b0;
                    c   = r[0];
                    r   = ((r & msk) >> 1) | ({31'b0, lin} << top) | (r & ~msk);
                end
            end
            exp_flags  = {r[top], (r & msk) == 32'h0, 3'b000, ~^(r & msk), 1'b0, c};
            exp_result = r;
        end else if (op inside {op_add, op_adc, op_sub, op_sbc, op_neg}) begin
            sub = op inside {op_sub, op_sbc, op_neg};
            c   = (op == op_adc || op == op_sbc) ? exp_flags[0] : 1'b0; // carry in
            a   = ((op == op_neg) ? 32'h0 : a0) & msk;
            b   = ((op == op_neg) ? a0 : a1) & msk;
            if (sub) begin
                full = {32'b0, a} - {32'b0, b} - {63'b0, c};
                h    = int'(a[3:0]) < int'(b[3:0]) + int'(c);
                c    = {32'b0, a} < {32'b0, b} + {63'b0, c};
                v    = (a[top] != b[top]) && (full[top] != a[top]);
            end else begin
                full = {32'b0, a} + {32'b0, b} + {63'b0, c};
                h    = int'(a[3:0]) + int'(b[3:0]) + int'(c) > 15;
                c    = full[top+1];
                v    = (a[top] == b[top]) && (full[top] != a[top]);
            end
            r         = full[31:0] & msk;
            exp_flags = {r[top], r == 32'h0, exp_flags[5], h, exp_flags[3], v, sub, c};
            if (!fo) exp_result = r | (a0 & ~msk);
        end else if (op inside {op_and, op_or, op_xor}) begin
            r         = ((op == op_and) ? (a0 & a1) : (op == op_or) ? (a0 | a1) : (a0 ^ a1)) & msk;
            exp_flags = {r[top], r == 32'h0, exp_flags[5], op == op_and, exp_flags[3], ~^r, 2'b00};
            if (!fo) exp_result = r | (a0 & ~msk);
        end else if (op == op_cpl) begin
            exp_flags[4] = 1'b1;
            exp_flags[1] = 1'b1;
            if (!fo) exp_result = (~a1 & msk) | (a0 & ~msk);
        end else if (op == op_move) begin
            if (!fo) exp_result = (a1 & msk) | (a0 & ~msk); // flags kept
        end else begin
            exp_flags[1] = 1'b0;
            if (op != op_ccf) exp_flags[4] = 1'b0;
            exp_flags[0] = (op == op_scf) ? 1'b1 : (op == op_rcf) ? 1'b0 : ~exp_flags[0];
        end
    endtask

    task automatic run_op(input string tag, input logic [4:0] op, input logic [1:0] w,
                          input logic fo, input logic [3:0] cnt, input logic [31:0] a0,
                          input logic [31:0] a1);
        string       name;
        logic [31:0] ctrl_word;
        logic [31:0] val;
        name      = $sformatf("%s op %02h w%0d fo%0d cnt%0d", tag, op, w, fo, cnt);
        ctrl_word = {20'b0, cnt, 1'b0, w, op};
        if (fo) ctrl_word[8] = 1'b1;
        write_reg(a_op0, a0, 1'b0, name);
        write_reg(a_op1, a1, 1'b0, name);
        write_reg(a_ctrl, ctrl_word, 1'b0, name);
        model_op(op, w, fo, cnt, a0, a1);
        wait_idle();
        read_reg(a_result, 1'b0, name, val);
        check_value({name, " result"}, exp_result, val);
        read_reg(a_flags, 1'b0, name, val);
        check_value({name, " flags"}, {24'b0, exp_flags}, val);
    endtask

    initial begin
        while (cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run hung after %0d cycles with %0d errors", cycles, errors);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        rst        = 1'b1;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = 8'h00;
        pwdata     = 32'h0;
        errors     = 0;
        cycles     = 0;
        seed       = 3;
        exp_result = 32'h0;
        exp_flags  = 8'h00;
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;

        // reset state
        read_reg(a_result, 1'b0, "reset result", rd);
        check_value("reset result", 32'h0, rd);
        read_reg(a_flags, 1'b0, "reset flags", rd);
        check_value("reset flags", 32'h0, rd);
        read_reg(a_status, 1'b0, "reset status", rd);
        check_value("reset status", 32'h0, rd);
        read_reg(a_op0, 1'b0, "reset op0", rd);
        check_value("reset op0", 32'h0, rd);

        // arithmetic, odd passes with flags_only
        for (int wi = 0; wi < 3; wi++) begin
            foreach (arith_ops[k]) begin
                for (int i = 0; i < 40; i++) begin
                    x = $random(seed);
                    y = $random(seed);
                    run_op("arith", arith_ops[k], 2'(wi), i[0], 4'd0, x, y);
                end
            end
        end

        for (int wi = 0; wi < 3; wi++) begin
            foreach (logic_ops[k]) begin
                for (int i = 0; i < 8; i++) begin
                    x = $random(seed);
                    y = $random(seed);
                    run_op("logic", logic_ops[k], 2'(wi), 1'b0, 4'd0, x, y);
                end
            end
        end
        foreach (flag_seq[k]) begin
            x = $random(seed);
            y = $random(seed);
            run_op("carry flag", flag_seq[k], 2'd2, 1'b0, 4'd0, x, y);
        end

        // shifts with count 0 (16 steps), 1 and two random counts
        for (int wi = 0; wi < 3; wi++) begin
            foreach (shift_ops[k]) begin
                for (int i = 0; i < 4; i++) begin
                    x  = $random(seed);
                    rd = $random(seed);
                    run_op("shift", shift_ops[k], 2'(wi), 1'b0,
                           (i < 2) ? 4'(i) : rd[3:0], x, 32'h0);
                end
            end
        end

        // new ctrl during a 16-step long rotate is refused
        x = $random(seed);
        y = $random(seed);
        write_reg(a_op0, x, 1'b0, "busy op0");
        write_reg(a_op1, y, 1'b0, "busy op1");
        write_reg(a_ctrl, {20'b0, 4'd0, 1'b0, 2'd2, op_rrc}, 1'b0, "busy ctrl");
        model_op(op_rrc, 2'd2, 1'b0, 4'd0, x, 32'h0);
        write_reg(a_ctrl, {27'b0, op_add}, 1'b1, "ctrl while busy");
        wait_idle();
        read_reg(a_result, 1'b0, "busy result", rd);
        check_value("busy result", exp_result, rd);
        read_reg(a_flags, 1'b0, "busy flags", rd);
        check_value("busy flags", {24'b0, exp_flags}, rd);

        // operand copies taken when the rotate started
        read_reg(a_op0, 1'b0, "op0 readback", rd);
        check_value("op0 readback", x, rd);
        read_reg(a_op1, 1'b0, "op1 readback", rd);
        check_value("op1 readback", y, rd);

        // read-only and unmapped accesses
        write_reg(a_result, 32'hDEAD_BEEF, 1'b1, "write result");
        write_reg(a_flags, 32'h0000_00FF, 1'b1, "write flags");
        write_reg(a_status, 32'h1, 1'b1, "write status");
        read_reg(a_ctrl, 1'b1, "read ctrl", rd);
        write_reg(8'h18, 32'h1234_5678, 1'b1, "write unmapped");
        read_reg(8'hFC, 1'b1, "read unmapped", rd);
        write_reg(8'h02, 32'h1, 1'b1, "write unaligned");
        read_reg(a_result, 1'b0, "result after errors", rd);
        check_value("result after errors", exp_result, rd);

        $display("run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
verilog/alu_pkg.sv
verilog/apb_regs.sv
verilog/alu_core.sv
verilog/shift_unit.sv
verilog/result_regs.sv
verilog/alu_periph.sv
sim/tb_alu_periph.sv

/* Bender.yml */
package:
  name: alu_periph

sources:
  - verilog/alu_pkg.sv
  - verilog/apb_regs.sv
  - verilog/alu_core.sv
  - verilog/shift_unit.sv
  - verilog/result_regs.sv
  - verilog/alu_periph.sv
  - target: simulation
    files:
      - sim/tb_alu_periph.sv
